/* common/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// fetch address and word widths
`define ADDR_WIDTH 32
`define XLEN 64

// cache geometry
`define SET_COUNT 64
`define WAY_COUNT 2
`define LINE_BEATS 4

// one line holds all beats of a burst
`define LINE_BITS (`XLEN * `LINE_BEATS)

// address field widths, derived from the geometry
`define INDEX_WIDTH ($clog2(`SET_COUNT))
`define OFFSET_WIDTH ($clog2(`LINE_BITS / 8))
`define TAG_WIDTH (`ADDR_WIDTH - `INDEX_WIDTH - `OFFSET_WIDTH)

// offset split into word select and byte within word
`define WORD_SEL_WIDTH ($clog2(`LINE_BEATS))
`define BYTE_SEL_WIDTH ($clog2(`XLEN / 8))

`endif

/* common/cacheAddrPkg.sv */
`default_nettype none

`include "cache_macros.svh"

package cacheAddrPkg;

  // set index into tag, valid, lru and data arrays
  typedef logic [`INDEX_WIDTH-1:0] lineIndex_t;

  // fetch address decoded for lookup
  // offset upper bits pick the word, lower bits the byte in it
  typedef struct packed {
    logic [`TAG_WIDTH-1:0]    tag;
    lineIndex_t               index;
    logic [`OFFSET_WIDTH-1:0] offset;
  } fetchAddrFields_t;

  // raw view for the bus side, field view for the arrays
  typedef union packed {
    logic [`ADDR_WIDTH-1:0] raw;
    fetchAddrFields_t       fields;
  } fetchAddr_t;

endpackage

`default_nettype wire

/* common/cacheBusPkg.sv */
`default_nettype none

`include "cache_macros.svh"

package cacheBusPkg;

  // request FSM states
  // replay re-reads the freshly filled line before compare
  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stMiss,
    stRefill,
    stReplay
  } ctrlState_t;

  // slot of the next refill beat within the line
  typedef logic [`WORD_SEL_WIDTH-1:0] beatCount_t;

endpackage

`default_nettype wire

/* cache/cacheCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  valid_i,
  input  wire  cacheHit_i,
  input  wire  rdReady_i,
  input  wire  rdLast_i,
  output logic addrOk_o,
  output logic dataOk_o,
  output logic dataNotOk_o,
  output logic rdValid_o,
  output logic lookupEn_o,
  output logic captureEn_o,
  output logic fillEn_o,
  output logic touchEn_o
);

  cacheBusPkg::ctrlState_t curState;
  cacheBusPkg::ctrlState_t nextState;

  // state decodes
  logic inIdle;
  logic inCompare;
  logic inMiss;
  logic inRefill;
  logic inReplay;

  // request taken on this edge
  logic accept;

  assign inIdle    = (curState == cacheBusPkg::stIdle);
  assign inCompare = (curState == cacheBusPkg::stCompare);
  assign inMiss    = (curState == cacheBusPkg::stMiss);
  assign inRefill  = (curState == cacheBusPkg::stRefill);
  assign inReplay  = (curState == cacheBusPkg::stReplay);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= cacheBusPkg::stIdle;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      cacheBusPkg::stIdle: begin
        if (valid_i) begin
          nextState = cacheBusPkg::stCompare;
        end
      end
      cacheBusPkg::stCompare: begin
        // a hit may take the next request in the same cycle
        if (!cacheHit_i) begin
          nextState = cacheBusPkg::stMiss;
        end else if (!valid_i) begin
          nextState = cacheBusPkg::stIdle;
        end
      end
      cacheBusPkg::stMiss: begin
        // hold the burst request until the bus takes it
        if (rdReady_i) begin
          nextState = cacheBusPkg::stRefill;
        end
      end
      cacheBusPkg::stRefill: begin
        if (rdLast_i) begin
          nextState = cacheBusPkg::stReplay;
        end
      end
      cacheBusPkg::stReplay: begin
        nextState = cacheBusPkg::stCompare;
      end
      default: begin
        nextState = cacheBusPkg::stIdle;
      end
    endcase
  end

  // core handshake
  assign addrOk_o    = inIdle || (inCompare && cacheHit_i);
  assign accept      = valid_i && addrOk_o;
  assign dataOk_o    = inCompare && cacheHit_i;
  // result still pending while the line is fetched
  assign dataNotOk_o = inMiss || inRefill || inReplay;

  // burst request stays up for the whole miss state
  assign rdValid_o = inMiss;

  // array reads on acceptance, and again after the fill
  assign lookupEn_o  = accept || inReplay;
  // refill latches each accepted address for a possible burst
  assign captureEn_o = accept;
  // last beat completes the line, written on that edge
  assign fillEn_o    = inRefill && rdLast_i;
  // a completed hit refreshes the lru mark
  assign touchEn_o   = inCompare && cacheHit_i;

endmodule

`default_nettype wire

/* cache/cacheTagArray.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheTagArray (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire cacheAddrPkg::fetchAddr_t addr_i,
  input  wire                       lookupEn_i,
  input  wire                       fillEn_i,
  input  wire                       touchEn_i,
  output logic [`WAY_COUNT-1:0]     wayHit_o,
  output logic                      victimWay_o
);

  // tags per way and set, no reset
  logic [`TAG_WIDTH-1:0] tagMem [`WAY_COUNT][`SET_COUNT];
  logic [`WAY_COUNT-1:0][`SET_COUNT-1:0] validMem;
  // one mark per set, names the way to evict next
  logic [`SET_COUNT-1:0] lruMem;

  cacheAddrPkg::fetchAddr_t reqAddr;
  cacheAddrPkg::lineIndex_t reqIdx;
  // cycle after a fill, the missed address must stay
  logic replayPend;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      replayPend <= 1'b0;
    end else begin
      replayPend <= fillEn_i;
    end
  end

  always_ff @(posedge clk) begin
    if (lookupEn_i && !replayPend) begin
      reqAddr <= addr_i;
    end
  end

  assign reqIdx = reqAddr.fields.index;

  // compare stored tags under their valid bits
  always_comb begin
    for (int w = 0; w < `WAY_COUNT; w++) begin
      wayHit_o[w] = validMem[w][reqIdx] && (tagMem[w][reqIdx] == reqAddr.fields.tag);
    end
  end

  // invalid way first, else the lru mark
  always_comb begin
    if (!validMem[0][reqIdx]) begin
      victimWay_o = 1'b0;
    end else if (!validMem[1][reqIdx]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = lruMem[reqIdx];
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagMem[victimWay_o][reqIdx] <= reqAddr.fields.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validMem <= '0;
      lruMem   <= '0;
    end else if (fillEn_i) begin
      validMem[victimWay_o][reqIdx] <= 1'b1;
      // filled way is now the most recent one
      lruMem[reqIdx] <= ~victimWay_o;
    end else if (touchEn_i) begin
      lruMem[reqIdx] <= ~wayHit_o[1];
    end
  end

endmodule

`default_nettype wire

/* cache/cacheDataArray.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheDataArray (
  input  wire                       clk,
  input  wire cacheAddrPkg::fetchAddr_t addr_i,
  input  wire                       lookupEn_i,
  input  wire                       fillEn_i,
  input  wire                       fillWay_i,
  input  wire [`LINE_BITS-1:0]      lineData_i,
  input  wire [`WAY_COUNT-1:0]      wayHit_i,
  output logic [`XLEN-1:0]          rdData_o
);

  // behavioral line storage, one line per way and set
  logic [`LINE_BITS-1:0] lineMem [`WAY_COUNT][`SET_COUNT];
  // synchronous read registers, one per way
  logic [`LINE_BITS-1:0] lineQ [`WAY_COUNT];

  cacheAddrPkg::fetchAddr_t reqAddr;
  cacheAddrPkg::lineIndex_t readIdx;
  logic [`WORD_SEL_WIDTH-1:0] wordSel;
  // high in replay, follows the fill by one cycle
  logic replayPend;

  always_ff @(posedge clk) begin
    replayPend <= fillEn_i;
    if (lookupEn_i && !replayPend) begin
      reqAddr <= addr_i;
    end
  end

  // replay re-reads the missed set, else the new request
  assign readIdx = replayPend ? reqAddr.fields.index : addr_i.fields.index;

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      lineMem[fillWay_i][reqAddr.fields.index] <= lineData_i;
    end
  end

  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      for (int w = 0; w < `WAY_COUNT; w++) begin
        lineQ[w] <= lineMem[w][readIdx];
      end
    end
  end

  // word select from the registered offset
  assign wordSel = reqAddr.fields.offset[`OFFSET_WIDTH-1:`BYTE_SEL_WIDTH];

  // hit vector is one-hot on a hit, zero otherwise
  always_comb begin
    rdData_o = '0;
    for (int w = 0; w < `WAY_COUNT; w++) begin
      if (wayHit_i[w]) begin
        rdData_o = rdData_o | lineQ[w][wordSel*`XLEN +: `XLEN];
      end
    end
  end

endmodule

`default_nettype wire

/* cache/cacheRefill.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheRefill (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire cacheAddrPkg::fetchAddr_t addr_i,
  input  wire                       captureEn_i,
  input  wire                       beatValid_i,
  input  wire [`XLEN-1:0]           rdData_i,
  output logic [`ADDR_WIDTH-1:0]    rdAddr_o,
  output logic [`LINE_BITS-1:0]     lineData_o
);

  cacheAddrPkg::fetchAddr_t lineAddr;
  cacheBusPkg::beatCount_t beatCnt;
  // beats gathered so far
  logic [`LINE_BITS-1:0] lineBuf;

  // latched at acceptance, held through the whole miss
  always_ff @(posedge clk) begin
    if (captureEn_i) begin
      lineAddr <= addr_i;
    end
  end

  // burst starts at the line boundary
  assign rdAddr_o = {lineAddr.raw[`ADDR_WIDTH-1:`OFFSET_WIDTH], {`OFFSET_WIDTH{1'b0}}};

  // cleared before every burst, steps once per beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (captureEn_i) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineBuf[beatCnt*`XLEN +: `XLEN] <= rdData_i;
    end
  end

  // merge the beat in flight
  // so the last beat reaches the fill on its own edge
  always_comb begin
    lineData_o = lineBuf;
    if (beatValid_i) begin
      lineData_o[beatCnt*`XLEN +: `XLEN] = rdData_i;
    end
  end

endmodule

`default_nettype wire

/* logic/icacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module icacheTop (
  input  wire                     clk,
  input  wire                     rst_n,
  // core side
  input  wire [`ADDR_WIDTH-1:0]   addr_i,
  input  wire                     valid_i,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output logic                    dataNotOk_o,
  output logic [`XLEN-1:0]        rdData_o,
  // read bus side
  output logic                    rdValid_o,
  input  wire                     rdReady_i,
  output logic [`ADDR_WIDTH-1:0]  rdAddr_o,
  output logic [7:0]              fetchLen_o,
  input  wire [`XLEN-1:0]         rdData_i,
  input  wire                     beatValid_i,
  input  wire                     rdLast_i
);

  cacheAddrPkg::fetchAddr_t coreAddr;

  logic lookupEn;
  logic captureEn;
  logic fillEn;
  logic touchEn;
  logic cacheHit;
  logic victimWay;
  logic [`WAY_COUNT-1:0] wayHit;
  logic [`LINE_BITS-1:0] lineData;

  assign coreAddr.raw = addr_i;
  assign cacheHit     = wayHit[0] | wayHit[1];
  // fixed burst length, minus one
  assign fetchLen_o   = 8'(`LINE_BEATS - 1);

  cacheCtrl uCtrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid_i),
    .cacheHit_i  (cacheHit),
    .rdReady_i   (rdReady_i),
    .rdLast_i    (rdLast_i),
    .addrOk_o    (addrOk_o),
    .dataOk_o    (dataOk_o),
    .dataNotOk_o (dataNotOk_o),
    .rdValid_o   (rdValid_o),
    .lookupEn_o  (lookupEn),
    .captureEn_o (captureEn),
    .fillEn_o    (fillEn),
    .touchEn_o   (touchEn)
  );

  cacheTagArray uTagArray (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr_i      (coreAddr),
    .lookupEn_i  (lookupEn),
    .fillEn_i    (fillEn),
    .touchEn_i   (touchEn),
    .wayHit_o    (wayHit),
    .victimWay_o (victimWay)
  );

  cacheDataArray uDataArray (
    .clk        (clk),
    .addr_i     (coreAddr),
    .lookupEn_i (lookupEn),
    .fillEn_i   (fillEn),
    .fillWay_i  (victimWay),
    .lineData_i (lineData),
    .wayHit_i   (wayHit),
    .rdData_o   (rdData_o)
  );

  cacheRefill uRefill (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr_i      (coreAddr),
    .captureEn_i (captureEn),
    .beatValid_i (beatValid_i),
    .rdData_i    (rdData_i),
    .rdAddr_o    (rdAddr_o),
    .lineData_o  (lineData)
  );

endmodule

`default_nettype wire

/* test/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset held for a fixed count, released between edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tbChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module tbChecker (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        valid_i,
  input  wire [31:0] addr_i,
  input  wire [1:0]  expKind_i,
  input  wire        addrOk_i,
  input  wire        dataOk_i,
  input  wire        dataNotOk_i,
  input  wire [63:0] rdData_i,
  input  wire        rdValid_i,
  input  wire [31:0] rdAddr_i,
  input  wire [7:0]  fetchLen_i,
  output int         errCount_o,
  output int         checkCount_o,
  output int         pending_o
);

  localparam logic [1:0] KIND_MODEL = 2'd2;

  // one accepted request waiting for its result
  typedef struct packed {
    logic [31:0] addr;
    logic        miss;
    int          acceptCycle;
  } pendReq_t;

  // reference model of tags and valid bits per way and set
  // address splits into a 21-bit tag, 6-bit index and 5-bit offset
  logic [20:0] tagModel [2][64];
  logic        validModel [2][64];
  // way to evict next in each set
  logic        lruModel [64];

  pendReq_t pendQ [$];
  pendReq_t head;
  pendReq_t newReq;
  int       cycle;
  int       refillSeen;
  logic     rdValidQ;
  logic     resetChecked;
  logic     predMiss;

  // word at dword address A is {~A, A}
  function automatic logic [63:0] memWord(input logic [31:0] a);
    logic [31:0] d;
    d = {a[31:3], 3'b000};
    return {~d, d};
  endfunction

  task automatic compareValue(input string name, input logic [63:0] exp, input logic [63:0] got);
    checkCount_o++;
    if (exp !== got) begin
      errCount_o++;
      $display("[ERROR] %0d ns %s exp %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic reportFault(input string msg);
    checkCount_o++;
    errCount_o++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  // a hit touches its way
  // a miss fills an invalid way first, else the lru way
  task automatic modelAccess(input logic [31:0] a, output logic miss);
    logic [20:0] tag;
    logic [5:0]  idx;
    logic        victim;
    tag  = a[31:11];
    idx  = a[10:5];
    miss = 1'b0;
    if (validModel[0][idx] && tagModel[0][idx] == tag) begin
      lruModel[idx] = 1'b1;
    end else if (validModel[1][idx] && tagModel[1][idx] == tag) begin
      lruModel[idx] = 1'b0;
    end else begin
      miss = 1'b1;
      if (!validModel[0][idx]) begin
        victim = 1'b0;
      end else if (!validModel[1][idx]) begin
        victim = 1'b1;
      end else begin
        victim = lruModel[idx];
      end
      tagModel[victim][idx]   = tag;
      validModel[victim][idx] = 1'b1;
      lruModel[idx]           = ~victim;
    end
  endtask

  // samples the values that were stable before the rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < 64; s++) begin
        validModel[0][s] = 1'b0;
        validModel[1][s] = 1'b0;
        lruModel[s]      = 1'b0;
      end
      pendQ.delete();
      cycle        = 0;
      refillSeen   = 0;
      rdValidQ     = 1'b0;
      resetChecked = 1'b0;
      errCount_o   = 0;
      checkCount_o = 0;
    end else begin
      cycle++;
      // idle outputs right after reset
      if (!resetChecked) begin
        compareValue("addrOk_o", 64'd1, {63'd0, addrOk_i});
        compareValue("dataOk_o", 64'd0, {63'd0, dataOk_i});
        compareValue("dataNotOk_o", 64'd0, {63'd0, dataNotOk_i});
        compareValue("rdValid_o", 64'd0, {63'd0, rdValid_i});
        compareValue("fetchLen_o", 64'd3, {56'd0, fetchLen_i});
        resetChecked = 1'b1;
      end
      if (dataOk_i && dataNotOk_i) begin
        reportFault("dataOk and dataNotOk are high together");
      end
      // no new request is taken while a miss is pending
      if (dataNotOk_i) begin
        compareValue("addrOk_o", 64'd0, {63'd0, addrOk_i});
      end
      // a new burst request belongs to the oldest pending request
      if (rdValid_i && !rdValidQ) begin
        if (pendQ.size() == 0 || !pendQ[0].miss) begin
          reportFault($sformatf("refill at %h while the model predicts no miss", rdAddr_i));
        end else begin
          compareValue("rdAddr_o", {32'd0, pendQ[0].addr[31:5], 5'd0}, {32'd0, rdAddr_i});
        end
        refillSeen++;
      end
      if (rdValid_i) begin
        compareValue("dataNotOk_o", 64'd1, {63'd0, dataNotOk_i});
      end
      // results return in request order
      if (dataOk_i) begin
        // a completing hit takes the next request in the same cycle
        compareValue("addrOk_o", 64'd1, {63'd0, addrOk_i});
        if (pendQ.size() == 0) begin
          reportFault("data returned with no request pending");
        end else begin
          head = pendQ.pop_front();
          compareValue("rdData_o", memWord(head.addr), rdData_i);
          if (head.miss && refillSeen != 1) begin
            reportFault($sformatf("miss at %h saw %0d refills", head.addr, refillSeen));
          end
          if (!head.miss && cycle != head.acceptCycle + 1) begin
            reportFault($sformatf("hit at %h took %0d cycles", head.addr,
                                  cycle - head.acceptCycle));
          end
        end
        refillSeen = 0;
      end
      if (valid_i && addrOk_i) begin
        modelAccess(addr_i, predMiss);
        // directed entries carry their own expected outcome
        if (expKind_i != KIND_MODEL && predMiss != expKind_i[0]) begin
          reportFault($sformatf("table expects miss=%0d at %h, model says %0d",
                                expKind_i[0], addr_i, predMiss));
        end
        newReq.addr        = addr_i;
        newReq.miss        = predMiss;
        newReq.acceptCycle = cycle;
        pendQ.push_back(newReq);
      end
      rdValidQ = rdValid_i;
    end
    pending_o = pendQ.size();
  end

endmodule

`default_nettype wire

/* test/tbTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tbTop;

  localparam logic [1:0] KIND_HIT   = 2'd0;
  localparam logic [1:0] KIND_MISS  = 2'd1;
  localparam logic [1:0] KIND_MODEL = 2'd2;
  localparam int WAIT_LIMIT  = 200;
  localparam int RAND_COUNT  = 48;
  localparam int RESP_IDLE   = 0;
  localparam int RESP_DELAY  = 1;
  localparam int RESP_GRANT  = 2;
  localparam int RESP_BEATS  = 3;

  // chain keeps valid high into the next entry
  typedef struct packed {
    logic [31:0] addr;
    logic        chain;
    logic [1:0]  kind;
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        coreValid = 1'b0;
  logic [31:0] coreAddr  = 32'd0;
  logic [1:0]  coreKind  = KIND_MODEL;
  logic        busReady  = 1'b0;
  logic [63:0] busData   = 64'd0;
  logic        beatValid = 1'b0;
  logic        busLast   = 1'b0;
  logic        addrOk;
  logic        dataOk;
  logic        dataNotOk;
  logic [63:0] rdData;
  logic        rdValid;
  logic [31:0] rdAddr;
  logic [7:0]  fetchLen;
  int          errCount;
  int          checkCount;
  int          pending;

  // responder state
  int          respState;
  int          waitCnt;
  int          beatIdx;
  logic [31:0] burstAddr;
  // grant delays drawn from the seeded stream
  int          grantDelay [$];

  entry_t stimTbl [$];

  // tags 0, 1 and 2 compete for the two ways of set 3
  // set 52 holds a second resident line
  entry_t directedTbl [0:16] = '{
    '{32'h0000_0060, 1'b0, KIND_MISS},
    '{32'h0000_0078, 1'b0, KIND_HIT},
    '{32'h0000_0068, 1'b0, KIND_HIT},
    '{32'h1234_5688, 1'b0, KIND_MISS},
    '{32'h1234_5690, 1'b0, KIND_HIT},
    '{32'h0000_0860, 1'b0, KIND_MISS},
    '{32'h0000_0070, 1'b0, KIND_HIT},
    '{32'h0000_1060, 1'b0, KIND_MISS},
    '{32'h0000_0860, 1'b0, KIND_MISS},
    '{32'h0000_1068, 1'b0, KIND_HIT},
    '{32'h0000_0060, 1'b0, KIND_MISS},
    '{32'h0000_1070, 1'b0, KIND_HIT},
    '{32'h0000_0068, 1'b1, KIND_HIT},
    '{32'h0000_1078, 1'b1, KIND_HIT},
    '{32'h0000_0070, 1'b1, KIND_HIT},
    '{32'h0000_1060, 1'b1, KIND_HIT},
    '{32'h1234_5698, 1'b0, KIND_HIT}
  };

  tbClock #(.PERIOD_NS(8), .RESET_CYCLES(10)) uClock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  icacheTop UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr_i      (coreAddr),
    .valid_i     (coreValid),
    .addrOk_o    (addrOk),
    .dataOk_o    (dataOk),
    .dataNotOk_o (dataNotOk),
    .rdData_o    (rdData),
    .rdValid_o   (rdValid),
    .rdReady_i   (busReady),
    .rdAddr_o    (rdAddr),
    .fetchLen_o  (fetchLen),
    .rdData_i    (busData),
    .beatValid_i (beatValid),
    .rdLast_i    (busLast)
  );

  tbChecker uChecker (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (coreValid),
    .addr_i       (coreAddr),
    .expKind_i    (coreKind),
    .addrOk_i     (addrOk),
    .dataOk_i     (dataOk),
    .dataNotOk_i  (dataNotOk),
    .rdData_i     (rdData),
    .rdValid_i    (rdValid),
    .rdAddr_i     (rdAddr),
    .fetchLen_i   (fetchLen),
    .errCount_o   (errCount),
    .checkCount_o (checkCount),
    .pending_o    (pending)
  );

  // word at dword address A is {~A, A}
  function automatic logic [63:0] memWord(input logic [31:0] a);
    logic [31:0] d;
    d = {a[31:3], 3'b000};
    return {~d, d};
  endfunction

  // memory responder grants after a random delay
  // and then returns four beats back to back
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      respState <= RESP_IDLE;
      busReady  <= 1'b0;
      beatValid <= 1'b0;
      busLast   <= 1'b0;
    end else begin
      case (respState)
        RESP_IDLE: begin
          if (rdValid) begin
            if (grantDelay.size() > 0) begin
              waitCnt <= grantDelay.pop_front();
            end else begin
              waitCnt <= 0;
            end
            burstAddr <= rdAddr;
            respState <= RESP_DELAY;
          end
        end
        RESP_DELAY: begin
          if (waitCnt == 0) begin
            busReady  <= 1'b1;
            respState <= RESP_GRANT;
          end else begin
            waitCnt <= waitCnt - 1;
          end
        end
        RESP_GRANT: begin
          // burst is taken on this edge and the first beat follows
          busReady  <= 1'b0;
          beatValid <= 1'b1;
          busData   <= memWord(burstAddr);
          busLast   <= 1'b0;
          beatIdx   <= 1;
          respState <= RESP_BEATS;
        end
        RESP_BEATS: begin
          if (beatIdx == 4) begin
            beatValid <= 1'b0;
            busLast   <= 1'b0;
            respState <= RESP_IDLE;
          end else begin
            busData <= memWord(burstAddr + beatIdx * 8);
            busLast <= (beatIdx == 3);
            beatIdx <= beatIdx + 1;
          end
        end
        default: begin
          respState <= RESP_IDLE;
        end
      endcase
    end
  end

  // directed part first, then random fetches over sets 9 and 10
  task automatic buildTable();
    entry_t e;
    foreach (directedTbl[k]) begin
      stimTbl.push_back(directedTbl[k]);
    end
    for (int k = 0; k < RAND_COUNT; k++) begin
      e.addr  = ((32'h100 + $urandom % 3) << 11) | ((32'd9 + $urandom % 2) << 5) |
                ($urandom % 32);
      e.chain = (($urandom % 2) == 1) && (k != RAND_COUNT - 1);
      e.kind  = KIND_MODEL;
      stimTbl.push_back(e);
    end
    // one grant delay per request covers every possible refill
    for (int k = 0; k < stimTbl.size(); k++) begin
      grantDelay.push_back($urandom % 4);
    end
  endtask

  task automatic waitReset(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
      ok = rst_n;
    end
  endtask

  task automatic waitAccept(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
      ok = addrOk;
    end
  endtask

  task automatic waitResult(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
      ok = dataOk;
    end
  endtask

  // checker counters settle away from the rising edge
  task automatic waitDrain(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
      ok = (pending == 0);
    end
  endtask

  initial begin : driveLoop
    int unsigned seedVal;
    bit ok;
    bit timedOut;
    int i;
    seedVal  = $urandom(32'h95a6add1);
    timedOut = 1'b0;
    buildTable();
    waitReset(ok);
    if (!ok) begin
      $display("timeout: reset was never released");
      timedOut = 1'b1;
    end
    i = 0;
    while (!timedOut && i < stimTbl.size()) begin
      coreValid <= 1'b1;
      coreAddr  <= stimTbl[i].addr;
      coreKind  <= stimTbl[i].kind;
      waitAccept(ok);
      if (!ok) begin
        $display("timeout: request %0d at %h was never accepted", i, stimTbl[i].addr);
        timedOut = 1'b1;
      end else if (!stimTbl[i].chain) begin
        coreValid <= 1'b0;
        waitResult(ok);
        if (!ok) begin
          $display("timeout: no data returned for request %0d", i);
          timedOut = 1'b1;
        end
      end
      i++;
    end
    waitDrain(ok);
    if (!ok) begin
      $display("timeout: %0d requests still pending at the end", pending);
      timedOut = 1'b1;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    $display("errors: %0d, checks: %0d", errCount, checkCount);
    if (!timedOut && errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/cacheAddrPkg.sv
common/cacheBusPkg.sv
cache/cacheCtrl.sv
cache/cacheTagArray.sv
cache/cacheDataArray.sv
cache/cacheRefill.sv
logic/icacheTop.sv
test/tbClock.sv
test/tbChecker.sv
test/tbTop.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module tbTop --Mdir obj_dir -o simTb; then
  echo "verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/simTb)
simStatus=$?
echo "$simOut"

if [ "$simStatus" -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

# the verdict comes from the printed status line only
if grep -qx "STATUS: PASS" <<< "$simOut"; then
  exit 0
fi
exit 1
